//--- integ_pkg.sv
// integrator control package with spi byte, timer count, command and sequencer types

package integ_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // timer value and readback word width
  localparam int COUNT_W = 32;

  // one spi byte sent msb first on the wire
  typedef logic [7:0] spi_byte_t;

  // integration timer value and also the readback word
  typedef logic [COUNT_W-1:0] count_t;

  //////////////////////////////
  // command codes
  //////////////////////////////

  // any other byte value is no command
  typedef enum spi_byte_t {
    // open the short so the capacitor integrates
    cmd_integrate = 8'hCA,
    // short the capacitor
    cmd_short     = 8'hCB,
    // zero the integration timer
    cmd_clear     = 8'hCC,
    // m_plus high for the 0 V reference
    cmd_ref_zero  = 8'hCD,
    // m_plus low for the 5 V reference
    cmd_ref_five  = 8'hCE
  } cmd_code_t;

  // command sequencer states
  // st_clearing lasts one cycle and then returns to where it came from
  typedef enum logic [1:0] {
    st_shorted     = 2'd0,
    st_integrating = 2'd1,
    st_clearing    = 2'd2
  } seq_state_t;

endpackage

//--- spi_rx_front.sv
// spi mode 0 receive front end: pin sync, edge and frame detect, byte deserializer
`timescale 1ns/1ps

module spi_rx_front (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sck,
  input  logic                ssel,
  input  logic                mosi,
  output integ_pkg::spi_byte_t rx_byte,
  output logic                rx_valid,
  output logic                sck_fall,
  output logic                frame_start,
  output logic                ssel_active
);

  import integ_pkg::*;

  //////////////////////////////
  // pin synchronizers
  //////////////////////////////

  // three stages for sck and ssel, oldest sample in bit 2
  logic [2:0] sck_r;
  logic [2:0] ssel_r;
  // two stages are enough for mosi, only sampled on sck rise
  logic [1:0] mosi_r;

  // byte assembly
  logic [2:0] bit_cnt;
  spi_byte_t  shift_in;
  logic       sck_rise;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      // idle bus: sck low, ssel deasserted
      sck_r  <= 3'b000;
      ssel_r <= 3'b111;
      mosi_r <= 2'b00;
    end
    else
    begin
      sck_r  <= {sck_r[1:0], sck};
      ssel_r <= {ssel_r[1:0], ssel};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  //////////////////////////////
  // edges and frame
  //////////////////////////////

  // compare the two older samples
  assign sck_rise    = (sck_r[2:1] == 2'b01);
  assign sck_fall    = (sck_r[2:1] == 2'b10);
  // ssel is active low
  assign ssel_active = ~ssel_r[1];
  // frame opens on the falling edge of ssel
  assign frame_start = (ssel_r[2:1] == 2'b10);

  //////////////////////////////
  // deserializer
  //////////////////////////////

  // bit counter held at zero between frames
  always_ff @(posedge clk)
  begin
    if (!rst_n || !ssel_active)
      bit_cnt <= 3'd0;
    else if (sck_rise)
      bit_cnt <= bit_cnt + 3'd1;
  end

  // msb first, so shift left and append at bit 0
  always_ff @(posedge clk)
  begin
    if (ssel_active && sck_rise)
      shift_in <= {shift_in[6:0], mosi_r[1]};
  end

  // strobe one cycle after the eighth rise, byte is complete then
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rx_valid <= 1'b0;
    else
      rx_valid <= ssel_active && sck_rise && (bit_cnt == 3'd7);
  end

  assign rx_byte = shift_in;

endmodule

//--- integ_sequencer.sv
// command sequencer: decodes spi bytes into switch, reference and timer controls
`timescale 1ns/1ps

module integ_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  integ_pkg::spi_byte_t rx_byte,
  input  logic                 rx_valid,
  output logic                 timer_run,
  output logic                 timer_clear,
  output logic                 m_reset,
  output logic                 m_plus,
  output logic                 m_gnd,
  output logic                 led
);

  import integ_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  // state to go back to after a clear
  seq_state_t ret_state;
  seq_state_t ret_state_nxt;

  // reference select, high means 0 V reference
  logic       ref_zero;
  cmd_code_t  cmd;

  // unknown codes fall through the case default
  assign cmd = cmd_code_t'(rx_byte);

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_comb
  begin
    state_nxt     = state;
    ret_state_nxt = ret_state;
    case (state)
      st_shorted:
      begin
        if (rx_valid)
        begin
          case (cmd)
            cmd_integrate: state_nxt = st_integrating;
            cmd_clear:
            begin
              state_nxt     = st_clearing;
              ret_state_nxt = st_shorted;
            end
            default: state_nxt = st_shorted;
          endcase
        end
      end
      st_integrating:
      begin
        if (rx_valid)
        begin
          case (cmd)
            cmd_short: state_nxt = st_shorted;
            cmd_clear:
            begin
              state_nxt     = st_clearing;
              ret_state_nxt = st_integrating;
            end
            default: state_nxt = st_integrating;
          endcase
        end
      end
      // single cycle, next byte is many cycles away
      st_clearing: state_nxt = ret_state;
      default:     state_nxt = st_shorted;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= st_shorted;
      ret_state <= st_shorted;
    end
    else
    begin
      state     <= state_nxt;
      ret_state <= ret_state_nxt;
    end
  end

  //////////////////////////////
  // reference flag
  //////////////////////////////

  // independent of the short state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      ref_zero <= 1'b0;
    else if (rx_valid && (cmd == cmd_ref_zero))
      ref_zero <= 1'b1;
    else if (rx_valid && (cmd == cmd_ref_five))
      ref_zero <= 1'b0;
  end

  // outputs decoded from state
  assign timer_run   = (state == st_integrating);
  assign timer_clear = (state == st_clearing);
  // m_reset high lets the switch open, capacitor integrates
  assign m_reset     = (state == st_integrating);
  assign led         = (state == st_integrating);
  // m_gnd always opposite of m_plus
  assign m_plus      = ref_zero;
  assign m_gnd       = ~ref_zero;

endmodule

//--- integ_timer.sv
// integration timer: prescaled tick counter, runs while integrating, clears on command
`timescale 1ns/1ps

module integ_timer #(
  // clk cycles per count
  parameter int TICK_DIV = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              timer_run,
  input  logic              timer_clear,
  output integ_pkg::count_t count
);

  import integ_pkg::*;

  // at least one bit so TICK_DIV of 1 still builds
  localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [PRE_W-1:0] pre_cnt;
  logic             tick;
  count_t           count_q;

  // last prescale cycle
  assign tick = (pre_cnt == PRE_W'(TICK_DIV - 1));

  //////////////////////////////
  // prescaler and count
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    // clear wins over run
    if (!rst_n || timer_clear)
    begin
      pre_cnt <= '0;
      count_q <= '0;
    end
    else if (timer_run)
    begin
      if (tick)
      begin
        pre_cnt <= '0;
        count_q <= count_q + count_t'(1);
      end
      else
      begin
        pre_cnt <= pre_cnt + PRE_W'(1);
      end
    end
    // run low: both hold
  end

  assign count = count_q;

endmodule

//--- spi_tx_readback.sv
// readback serializer: captures the timer at frame start and shifts it out on miso
`timescale 1ns/1ps

module spi_tx_readback (
  input  logic              clk,
  input  logic              rst_n,
  input  integ_pkg::count_t count,
  input  logic              frame_start,
  input  logic              sck_fall,
  input  logic              ssel_active,
  output logic              miso
);

  import integ_pkg::*;

  // readback word, msb goes out first
  count_t shift_out;

  //////////////////////////////
  // capture and shift
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      shift_out <= '0;
    end
    else if (frame_start)
    begin
      // snapshot before the first sck rise
      shift_out <= count;
    end
    else if (ssel_active && sck_fall)
    begin
      // mode 0: next bit set up on the falling edge
      shift_out <= {shift_out[COUNT_W-2:0], 1'b0};
    end
  end

  // single slave, miso driven all the time
  assign miso = shift_out[COUNT_W-1];

endmodule

//--- integ_top.sv
// integrator controller top: spi slave front end, command sequencer, timer and readback
`timescale 1ns/1ps

module integ_top #(
  // timer prescale in clk cycles
  parameter int TICK_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic m_reset,
  output logic m_plus,
  output logic m_gnd,
  output logic led
);

  import integ_pkg::*;

  // receive side
  spi_byte_t rx_byte;
  logic      rx_valid;
  logic      sck_fall;
  logic      frame_start;
  logic      ssel_active;

  // timer controls
  logic      timer_run;
  logic      timer_clear;
  count_t    count;

  //////////////////////////////
  // blocks
  //////////////////////////////

  spi_rx_front u_rx_front (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .ssel        (ssel),
    .mosi        (mosi),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .sck_fall    (sck_fall),
    .frame_start (frame_start),
    .ssel_active (ssel_active)
  );

  // led and m_gnd come straight out of here
  integ_sequencer u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .timer_run   (timer_run),
    .timer_clear (timer_clear),
    .m_reset     (m_reset),
    .m_plus      (m_plus),
    .m_gnd       (m_gnd),
    .led         (led)
  );

  integ_timer #(
    .TICK_DIV (TICK_DIV)
  ) u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .timer_run   (timer_run),
    .timer_clear (timer_clear),
    .count       (count)
  );

  spi_tx_readback u_tx_readback (
    .clk         (clk),
    .rst_n       (rst_n),
    .count       (count),
    .frame_start (frame_start),
    .sck_fall    (sck_fall),
    .ssel_active (ssel_active),
    .miso        (miso)
  );

endmodule

//--- tb_integ_checker.sv
// testbench checker that models the readback rules and compares the DUT ports
`timescale 1ns/1ps

module tb_integ_checker (
  input  logic        clk,
  input  logic        miso,
  input  logic        m_reset,
  input  logic        m_plus,
  input  logic        m_gnd,
  input  logic        led,
  input  int          test_num,
  input  logic        chk_req,
  input  logic [1:0]  chk_kind,
  input  logic [7:0]  chk_cmd,
  input  logic        chk_has_rb,
  input  logic        exp_r,
  input  logic        exp_p,
  input  logic        exp_g,
  input  logic [31:0] rb_word,
  output logic        chk_done,
  output int          err_count,
  output int          check_count,
  output int          test_count
);

  localparam int PORT_TIMEOUT = 100;

  // expected model
  logic        model_int;
  logic [31:0] prev_rb;
  // first read after a short may exceed the last read while integrating
  logic        rb_at_least;
  int          test_errs;

  initial
  begin
    chk_done    = 1'b0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    model_int   = 1'b0;
    prev_rb     = '0;
    rb_at_least = 1'b0;
    test_errs   = 0;
  end

  task automatic report(input string msg);
    err_count++;
    test_errs++;
    $display("error @ %0t: test %0d %s", $time, test_num, msg);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
      report($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  task automatic end_test(input string label);
    test_count++;
    if (test_errs == 0)
      $display("test %0d %s: ok", test_num, label);
    else
      $display("test %0d %s: %0d mismatches", test_num, label, test_errs);
    test_errs = 0;
  endtask

  function automatic logic ports_match;
    ports_match = (m_reset === exp_r) && (led === exp_r) &&
                  (m_plus === exp_p) && (m_gnd === exp_g);
  endfunction

  //////////////////////////////
  // per kind checks
  //////////////////////////////

  task automatic check_reset;
    // shorted with 5 V reference and readback idle
    check_bit("m_reset", m_reset, 1'b0);
    check_bit("m_plus", m_plus, 1'b0);
    check_bit("m_gnd", m_gnd, 1'b1);
    check_bit("led", led, 1'b0);
    check_bit("miso", miso, 1'b0);
    end_test("reset values");
  endtask

  task automatic check_command;
    int waited;
    case (chk_cmd)
      8'hCA: model_int = 1'b1;
      8'hCB:
      begin
        if (model_int)
          rb_at_least = 1'b1;
        model_int = 1'b0;
      end
      8'hCC:
      begin
        prev_rb     = '0;
        rb_at_least = 1'b0;
      end
      // reference and unknown bytes leave the timer model alone
      default: ;
    endcase
    waited = 0;
    while (!ports_match() && waited < PORT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!ports_match())
      $display("timeout: outputs did not settle within %0d cycles in test %0d",
               PORT_TIMEOUT, test_num);
    check_bit("m_reset", m_reset, exp_r);
    check_bit("led", led, exp_r);
    check_bit("m_plus", m_plus, exp_p);
    check_bit("m_gnd", m_gnd, exp_g);
    if (!chk_has_rb)
      end_test($sformatf("cmd %02h", chk_cmd));
  endtask

  task automatic check_readback;
    check_count++;
    if (model_int)
    begin
      // timer running between the two captures
      if (!(rb_word > prev_rb))
        report($sformatf("readback %0d not above previous %0d", rb_word, prev_rb));
    end
    else if (rb_at_least)
    begin
      if (rb_word < prev_rb)
        report($sformatf("readback %0d below last running value %0d", rb_word, prev_rb));
      rb_at_least = 1'b0;
    end
    else if (rb_word !== prev_rb)
    begin
      report($sformatf("readback %0d, frozen timer expected %0d", rb_word, prev_rb));
    end
    prev_rb = rb_word;
    // zero fill after 32 shifts
    check_bit("miso after frame", miso, 1'b0);
    end_test($sformatf("cmd %02h with readback %0d", chk_cmd, rb_word));
  endtask

  always @(posedge clk)
  begin
    if (chk_req && !chk_done)
    begin
      // sample ports away from the active edge
      @(negedge clk);
      case (chk_kind)
        2'd0: check_reset();
        2'd1: check_command();
        default: check_readback();
      endcase
      chk_done = 1'b1;
    end
    else if (!chk_req)
    begin
      chk_done = 1'b0;
    end
  end

endmodule

//--- tb_integ.sv
// testbench top for the integrator controller with clock, reset, spi master and command table
`timescale 1ns/1ps

module tb_integ;

  localparam int TICK_DIV     = 4;
  // sck half period in clk cycles
  localparam int HALF_SCK     = 10;
  localparam int DONE_TIMEOUT = 2000;
  localparam int N_STEPS      = 19;

  logic clk;
  logic rst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic m_reset;
  logic m_plus;
  logic m_gnd;
  logic led;

  // checker request and answer
  int          test_num;
  logic        chk_req;
  logic [1:0]  chk_kind;
  logic [7:0]  chk_cmd;
  logic        chk_has_rb;
  logic        exp_r;
  logic        exp_p;
  logic        exp_g;
  logic [31:0] rb_word;
  logic        chk_done;
  int          err_count;
  int          check_count;
  int          test_count;
  logic        timed_out;

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  // command byte, readback follows, expected m_reset m_plus m_gnd
  logic [7:0]  tbl_cmd [N_STEPS];
  logic        tbl_rb  [N_STEPS];
  logic [2:0]  tbl_exp [N_STEPS];

  int          step;
  logic [31:0] rx_unused;

  integ_top #(
    .TICK_DIV (TICK_DIV)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .sck     (sck),
    .ssel    (ssel),
    .mosi    (mosi),
    .miso    (miso),
    .m_reset (m_reset),
    .m_plus  (m_plus),
    .m_gnd   (m_gnd),
    .led     (led)
  );

  tb_integ_checker u_checker (
    .clk         (clk),
    .miso        (miso),
    .m_reset     (m_reset),
    .m_plus      (m_plus),
    .m_gnd       (m_gnd),
    .led         (led),
    .test_num    (test_num),
    .chk_req     (chk_req),
    .chk_kind    (chk_kind),
    .chk_cmd     (chk_cmd),
    .chk_has_rb  (chk_has_rb),
    .exp_r       (exp_r),
    .exp_p       (exp_p),
    .exp_g       (exp_g),
    .rb_word     (rb_word),
    .chk_done    (chk_done),
    .err_count   (err_count),
    .check_count (check_count),
    .test_count  (test_count)
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic set_step(input int idx, input logic [7:0] cmd, input logic rb,
                          input logic [2:0] exp_bits);
    tbl_cmd[idx] = cmd;
    tbl_rb[idx]  = rb;
    tbl_exp[idx] = exp_bits;
  endtask

  task automatic load_table;
    set_step(0,  8'hCA, 1'b0, 3'b101);
    set_step(1,  8'hCB, 1'b0, 3'b001);
    // reference select leaves the short alone
    set_step(2,  8'hCD, 1'b0, 3'b010);
    set_step(3,  8'hCA, 1'b0, 3'b110);
    set_step(4,  8'hCE, 1'b0, 3'b101);
    set_step(5,  8'hCB, 1'b0, 3'b001);
    // clear while shorted and then frozen
    set_step(6,  8'hCC, 1'b1, 3'b001);
    set_step(7,  8'h00, 1'b1, 3'b001);
    // counting
    set_step(8,  8'hCA, 1'b1, 3'b101);
    set_step(9,  8'hFF, 1'b1, 3'b101);
    // stop and then unknown bytes
    set_step(10, 8'hCB, 1'b1, 3'b001);
    set_step(11, 8'hC9, 1'b1, 3'b001);
    set_step(12, 8'hFF, 1'b1, 3'b001);
    set_step(13, 8'hCD, 1'b1, 3'b010);
    set_step(14, 8'hCE, 1'b0, 3'b001);
    // clear while integrating
    set_step(15, 8'hCA, 1'b0, 3'b101);
    set_step(16, 8'hCC, 1'b1, 3'b101);
    set_step(17, 8'hCB, 1'b1, 3'b001);
    set_step(18, 8'h00, 1'b1, 3'b001);
  endtask

  //////////////////////////////
  // spi master in mode 0
  //////////////////////////////

  task automatic spi_frame(input logic [31:0] tx, input int nbits, output logic [31:0] rx);
    int i;
    rx = '0;
    ssel = 1'b0;
    for (i = nbits - 1; i >= 0; i--)
    begin
      mosi = tx[i];
      repeat (HALF_SCK) @(posedge clk);
      #1;
      // master samples miso with the rising edge
      rx = {rx[30:0], miso};
      sck = 1'b1;
      repeat (HALF_SCK) @(posedge clk);
      #1;
      sck = 1'b0;
    end
    repeat (HALF_SCK) @(posedge clk);
    #1;
    ssel = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic idle_gap;
    int n;
    n = 8 + ($urandom % 16);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic note_timeout(input string reason);
    $display("%s", reason);
    timed_out = 1'b1;
  endtask

  // request / acknowledge with the checker
  task automatic run_check(input logic [1:0] kind);
    int waited;
    chk_kind = kind;
    chk_req  = 1'b1;
    waited   = 0;
    while (!chk_done && waited < DONE_TIMEOUT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    chk_req = 1'b0;
    if (!chk_done)
      note_timeout($sformatf("timeout: checker gave no answer in test %0d", test_num));
    else
    begin
      waited = 0;
      while (chk_done && waited < DONE_TIMEOUT)
      begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (chk_done)
        note_timeout($sformatf("timeout: checker did not release in test %0d", test_num));
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    void'($urandom(96));
    rst_n      = 1'b0;
    sck        = 1'b0;
    ssel       = 1'b1;
    mosi       = 1'b0;
    test_num   = 0;
    chk_req    = 1'b0;
    chk_kind   = 2'd0;
    chk_cmd    = 8'h00;
    chk_has_rb = 1'b0;
    exp_r      = 1'b0;
    exp_p      = 1'b0;
    exp_g      = 1'b0;
    rb_word    = '0;
    timed_out  = 1'b0;
    load_table();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // test 0 checks the reset values
    run_check(2'd0);
    for (step = 0; step < N_STEPS && !timed_out; step++)
    begin
      test_num   = step + 1;
      chk_cmd    = tbl_cmd[step];
      chk_has_rb = tbl_rb[step];
      {exp_r, exp_p, exp_g} = tbl_exp[step];
      idle_gap();
      spi_frame({24'h0, tbl_cmd[step]}, 8, rx_unused);
      run_check(2'd1);
      if (tbl_rb[step] && !timed_out)
      begin
        idle_gap();
        // four 0x00 bytes clock the word out
        spi_frame(32'h0, 32, rb_word);
        run_check(2'd2);
      end
    end
    repeat (20) @(posedge clk);
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0 && !timed_out)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- flist.f
integ_pkg.sv
spi_rx_front.sv
integ_sequencer.sv
integ_timer.sv
spi_tx_readback.sv
integ_top.sv
tb_integ_checker.sv
tb_integ.sv

//--- Bender.yml
package:
  name: integ_ctrl

dependencies: {}

sources:
  # design, package first
  - integ_pkg.sv
  - spi_rx_front.sv
  - integ_sequencer.sv
  - integ_timer.sv
  - spi_tx_readback.sv
  - integ_top.sv

  # testbench
  - target: test
    files:
      - tb_integ_checker.sv
      - tb_integ.sv
